// ==== src/rv_pkg.sv ====
package rv_pkg;

    // data and address width
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // major opcodes kept by the pipeline
    localparam logic [6:0] OP_R_TYPE = 7'b0110011;
    localparam logic [6:0] OP_I_TYPE = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    // funct3 for register alu ops
    localparam logic [2:0] R_FUN3_ADD_SUB = 3'b000;
    localparam logic [2:0] R_FUN3_SLL     = 3'b001;
    localparam logic [2:0] R_FUN3_SLT     = 3'b010;
    localparam logic [2:0] R_FUN3_SLTU    = 3'b011;
    localparam logic [2:0] R_FUN3_XOR     = 3'b100;
    localparam logic [2:0] R_FUN3_SRL_SRA = 3'b101;
    localparam logic [2:0] R_FUN3_OR      = 3'b110;
    localparam logic [2:0] R_FUN3_AND     = 3'b111;

    // funct3 for immediate alu ops
    localparam logic [2:0] I_FUN3_ADDI      = 3'b000;
    localparam logic [2:0] I_FUN3_SLLI      = 3'b001;
    localparam logic [2:0] I_FUN3_SLTI      = 3'b010;
    localparam logic [2:0] I_FUN3_SLTIU     = 3'b011;
    localparam logic [2:0] I_FUN3_XORI      = 3'b100;
    localparam logic [2:0] I_FUN3_SRLI_SRAI = 3'b101;
    localparam logic [2:0] I_FUN3_ORI       = 3'b110;
    localparam logic [2:0] I_FUN3_ANDI      = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // fetch to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fet_dec_t;

    // decode to execute, operands already selected
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       operand1;
        logic [XLEN-1:0]       operand2;
        alu_op_t               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
    } dec_exe_t;

    // execute to writeback
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
    } exe_wb_t;

endpackage

// ==== src/stage_slot.sv ====
module stage_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_load,
    input  payload_t i_data,
    input  logic     i_take,
    output logic     o_valid,
    output payload_t o_data
);

    logic     valid_q;
    payload_t data_q;

    // load wins over take in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (i_load) begin
            valid_q <= 1'b1;
        end else if (i_take) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

// ==== src/fetch_unit.sv ====
module fetch_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_fetch_valid,
    input  logic [rv_pkg::XLEN-1:0] i_fetch_instr,
    input  logic                   i_slot_free,
    output logic                   o_fetch_req,
    output logic [rv_pkg::XLEN-1:0] o_fetch_addr,
    output logic                   o_load,
    output rv_pkg::fet_dec_t       o_item
);

    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] held_instr;
    logic                    req_q;
    logic                    pending;
    logic                    held;

    // move the held instruction on once decode has room
    assign o_load = held & i_slot_free;

    // one request at a time
    // next one goes out right after the previous instruction is loaded
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= ~req_q & ~pending & (~held | o_load);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (req_q) begin
            pending <= 1'b1;
        end else if (i_fetch_valid) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else if (i_fetch_valid) begin
            held <= 1'b1;
        end else if (o_load) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetch_valid) begin
            held_instr <= i_fetch_instr;
        end
    end

    // pc stays on the fetched address until the slot load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (o_load) begin
            pc <= pc + rv_pkg::PC_STEP;
        end
    end

    assign o_fetch_req  = req_q;
    assign o_fetch_addr = pc;

    assign o_item.pc    = pc;
    assign o_item.instr = held_instr;

endmodule

// ==== src/decode_stage.sv ====
module decode_stage (
    input  logic                         i_valid,
    input  rv_pkg::fet_dec_t             i_item,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
    input  logic                         i_exe_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_exe_rd,
    input  logic                         i_exe_we,
    input  logic                         i_wb_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic                         i_wb_we,
    input  logic                         i_next_free,
    output logic                         o_take,
    output rv_pkg::dec_exe_t             o_item
);

    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pkg::XLEN-1:0]       imm_i;
    logic [rv_pkg::XLEN-1:0]       imm_u;
    logic                          kept;
    logic                          use_rs1;
    logic                          use_rs2;
    logic                          rs1_hazard;
    logic                          rs2_hazard;

    assign opcode = i_item.instr[6:0];
    assign rd     = i_item.instr[11:7];
    assign funct3 = i_item.instr[14:12];
    assign rs1    = i_item.instr[19:15];
    assign rs2    = i_item.instr[24:20];
    assign funct7 = i_item.instr[31:25];

    assign imm_i = {{20{i_item.instr[31]}}, i_item.instr[31:20]};
    assign imm_u = {i_item.instr[31:12], 12'b0};

    assign o_rs1_addr = rs1;
    assign o_rs2_addr = rs2;

    // operand and alu op selection per opcode
    always_comb begin
        kept            = 1'b0;
        use_rs1         = 1'b0;
        use_rs2         = 1'b0;
        o_item.operand1 = '0;
        o_item.operand2 = '0;
        o_item.alu_op   = rv_pkg::ALU_ADD;
        case (opcode)
            rv_pkg::OP_R_TYPE: begin
                kept            = 1'b1;
                use_rs1         = 1'b1;
                use_rs2         = 1'b1;
                o_item.operand1 = i_rs1_data;
                o_item.operand2 = i_rs2_data;
                case (funct3)
                    rv_pkg::R_FUN3_ADD_SUB:
                        o_item.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    rv_pkg::R_FUN3_SLL:  o_item.alu_op = rv_pkg::ALU_SLL;
                    rv_pkg::R_FUN3_SLT:  o_item.alu_op = rv_pkg::ALU_SLT;
                    rv_pkg::R_FUN3_SLTU: o_item.alu_op = rv_pkg::ALU_SLTU;
                    rv_pkg::R_FUN3_XOR:  o_item.alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::R_FUN3_SRL_SRA:
                        o_item.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    rv_pkg::R_FUN3_OR:   o_item.alu_op = rv_pkg::ALU_OR;
                    default:             o_item.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OP_I_TYPE: begin
                kept            = 1'b1;
                use_rs1         = 1'b1;
                o_item.operand1 = i_rs1_data;
                // shamt sits in the low imm bits
                o_item.operand2 = imm_i;
                case (funct3)
                    rv_pkg::I_FUN3_ADDI:  o_item.alu_op = rv_pkg::ALU_ADD;
                    rv_pkg::I_FUN3_SLLI:  o_item.alu_op = rv_pkg::ALU_SLL;
                    rv_pkg::I_FUN3_SLTI:  o_item.alu_op = rv_pkg::ALU_SLT;
                    rv_pkg::I_FUN3_SLTIU: o_item.alu_op = rv_pkg::ALU_SLTU;
                    rv_pkg::I_FUN3_XORI:  o_item.alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::I_FUN3_SRLI_SRAI:
                        o_item.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    rv_pkg::I_FUN3_ORI:   o_item.alu_op = rv_pkg::ALU_OR;
                    default:              o_item.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OP_LUI: begin
                kept            = 1'b1;
                o_item.operand2 = imm_u;
            end
            rv_pkg::OP_AUIPC: begin
                kept            = 1'b1;
                o_item.operand1 = i_item.pc;
                o_item.operand2 = imm_u;
            end
            default: begin
                // unsupported, retires with no write
                kept = 1'b0;
            end
        endcase
    end

    assign o_item.pc = i_item.pc;
    assign o_item.rd = rd;
    assign o_item.we = kept & (rd != '0);

    // wait for older writers still in flight, no forwarding
    assign rs1_hazard = use_rs1 && (rs1 != '0) &&
                        ((i_exe_valid && i_exe_we && (i_exe_rd == rs1)) ||
                         (i_wb_valid && i_wb_we && (i_wb_rd == rs1)));
    assign rs2_hazard = use_rs2 && (rs2 != '0) &&
                        ((i_exe_valid && i_exe_we && (i_exe_rd == rs2)) ||
                         (i_wb_valid && i_wb_we && (i_wb_rd == rs2)));

    assign o_take = i_valid & i_next_free & ~rs1_hazard & ~rs2_hazard;

endmodule

// ==== src/reg_file.sv ====
module reg_file (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data,
    input  logic                         i_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_rd_data
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

    // x0 is cleared at reset and skipped on write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    assign o_rs1_data = regs[i_rs1_addr];
    assign o_rs2_data = regs[i_rs2_addr];

endmodule

// ==== src/alu.sv ====
module alu (
    input  rv_pkg::alu_op_t         i_op,
    input  logic [rv_pkg::XLEN-1:0] i_a,
    input  logic [rv_pkg::XLEN-1:0] i_b,
    output logic [rv_pkg::XLEN-1:0] o_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        o_result = '0;
        case (i_op)
            rv_pkg::ALU_ADD: begin
                o_result = i_a + i_b;
            end
            rv_pkg::ALU_SUB: begin
                o_result = i_a - i_b;
            end
            rv_pkg::ALU_AND: begin
                o_result = i_a & i_b;
            end
            rv_pkg::ALU_OR: begin
                o_result = i_a | i_b;
            end
            rv_pkg::ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            rv_pkg::ALU_SLL: begin
                o_result = i_a << shamt;
            end
            rv_pkg::ALU_SRL: begin
                o_result = i_a >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                o_result = $unsigned($signed(i_a) >>> shamt);
            end
            rv_pkg::ALU_SLT: begin
                o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            rv_pkg::ALU_SLTU: begin
                o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

// ==== src/rv_core_top.sv ====
module rv_core_top (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         o_fetch_req,
    output logic [rv_pkg::XLEN-1:0]       o_fetch_addr,
    input  logic                         i_fetch_valid,
    input  logic [rv_pkg::XLEN-1:0]       i_fetch_instr,
    output logic                         o_retire_valid,
    output logic [rv_pkg::XLEN-1:0]       o_retire_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_retire_rd,
    output logic [rv_pkg::XLEN-1:0]       o_retire_data,
    output logic                         o_retire_we
);

    // fetch to decode slot
    logic             fd_load;
    logic             fd_take;
    logic             fd_valid;
    rv_pkg::fet_dec_t fd_in;
    rv_pkg::fet_dec_t fd_data;

    // decode to execute slot
    logic             de_take;
    logic             de_valid;
    rv_pkg::dec_exe_t de_in;
    rv_pkg::dec_exe_t de_data;

    // execute to writeback slot
    logic             ew_take;
    logic             ew_valid;
    rv_pkg::exe_wb_t  ew_in;
    rv_pkg::exe_wb_t  ew_data;

    logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::XLEN-1:0]       alu_result;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_instr (i_fetch_instr),
        .i_slot_free   (~fd_valid | fd_take),
        .o_fetch_req   (o_fetch_req),
        .o_fetch_addr  (o_fetch_addr),
        .o_load        (fd_load),
        .o_item        (fd_in)
    );

    stage_slot #(.payload_t(rv_pkg::fet_dec_t)) u_fd_slot (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_load  (fd_load),
        .i_data  (fd_in),
        .i_take  (fd_take),
        .o_valid (fd_valid),
        .o_data  (fd_data)
    );

    decode_stage u_decode (
        .i_valid     (fd_valid),
        .i_item      (fd_data),
        .o_rs1_addr  (rs1_addr),
        .o_rs2_addr  (rs2_addr),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .i_exe_valid (de_valid),
        .i_exe_rd    (de_data.rd),
        .i_exe_we    (de_data.we),
        .i_wb_valid  (ew_valid),
        .i_wb_rd     (ew_data.rd),
        .i_wb_we     (ew_data.we),
        .i_next_free (~de_valid | de_take),
        .o_take      (fd_take),
        .o_item      (de_in)
    );

    // decode take doubles as the load into execute
    stage_slot #(.payload_t(rv_pkg::dec_exe_t)) u_de_slot (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_load  (fd_take),
        .i_data  (de_in),
        .i_take  (de_take),
        .o_valid (de_valid),
        .o_data  (de_data)
    );

    alu u_alu (
        .i_op     (de_data.alu_op),
        .i_a      (de_data.operand1),
        .i_b      (de_data.operand2),
        .o_result (alu_result)
    );

    assign de_take = de_valid & (~ew_valid | ew_take);

    assign ew_in.pc     = de_data.pc;
    assign ew_in.result = alu_result;
    assign ew_in.rd     = de_data.rd;
    assign ew_in.we     = de_data.we;

    stage_slot #(.payload_t(rv_pkg::exe_wb_t)) u_ew_slot (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_load  (de_take),
        .i_data  (ew_in),
        .i_take  (ew_take),
        .o_valid (ew_valid),
        .o_data  (ew_data)
    );

    // writeback never stalls
    assign ew_take = ew_valid;

    reg_file u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (o_retire_we),
        .i_rd_addr  (ew_data.rd),
        .i_rd_data  (ew_data.result)
    );

    assign o_retire_valid = ew_valid;
    assign o_retire_pc    = ew_data.pc;
    assign o_retire_rd    = ew_data.rd;
    assign o_retire_data  = ew_data.result;
    assign o_retire_we    = ew_valid & ew_data.we;

endmodule

// ==== sim/rv_core_checker.sv ====
module rv_core_checker (
    input logic clk,
    input logic rst_n,
    input logic i_fetch_req,
    input logic i_fetch_valid,
    input logic i_retire_valid,
    input logic i_retire_we
);

    logic outstanding;
    int   fail_count = 0;

    // request in flight as seen at the ports
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (i_fetch_req) begin
            outstanding <= 1'b1;
        end else if (i_fetch_valid) begin
            outstanding <= 1'b0;
        end
    end

    req_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
        i_fetch_req |-> !outstanding)
        else begin
            fail_count++;
            $error("fetch request issued while another one is pending");
        end

    resp_without_req: assert property (@(posedge clk) disable iff (!rst_n)
        i_fetch_valid |-> outstanding)
        else begin
            fail_count++;
            $error("fetch response arrived with no request pending");
        end

    we_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        i_retire_we |-> i_retire_valid)
        else begin
            fail_count++;
            $error("retire write flag high without the retire strobe");
        end

    // first edge with reset released
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !i_fetch_req && !i_retire_valid)
        else begin
            fail_count++;
            $error("fetch request or retire strobe in the first cycle after reset");
        end

endmodule

bind rv_core_top rv_core_checker chk0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_fetch_req    (o_fetch_req),
    .i_fetch_valid  (i_fetch_valid),
    .i_retire_valid (o_retire_valid),
    .i_retire_we    (o_retire_we)
);

// ==== sim/tb_rv_core.sv ====
module tb_rv_core;

    localparam int          N_INSTR    = 400;
    localparam int          MAX_CYCLES = N_INSTR * 12;
    localparam logic [31:0] SEED       = 32'd84737;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

    logic        clk;
    logic        rst_n;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        fetch_valid;
    logic [31:0] fetch_instr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        retire_we;

    logic [31:0] lfsr;
    logic [31:0] program_mem [N_INSTR];
    logic [31:0] model_regs [32];
    logic        mem_busy;
    logic [31:0] mem_addr;
    logic [31:0] mem_delay;
    int          mem_wait;
    int          fetch_count;
    int          retire_count;
    int          cycles;
    int          value_errors;
    int          other_errors;

    rv_core_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .o_fetch_req    (fetch_req),
        .o_fetch_addr   (fetch_addr),
        .i_fetch_valid  (fetch_valid),
        .i_fetch_instr  (fetch_instr),
        .o_retire_valid (retire_valid),
        .o_retire_pc    (retire_pc),
        .o_retire_rd    (retire_rd),
        .o_retire_data  (retire_data),
        .o_retire_we    (retire_we)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit
    task automatic draw(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // registers limited to x0..x7 so dependencies show up often
    task automatic build_program();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] alt;
        logic [31:0] imm;
        logic [6:0]  f7;
        logic [6:0]  other_op;
        logic [11:0] imm12;
        for (int i = 0; i < N_INSTR; i++) begin
            draw(4, kind);
            draw(3, rd);
            draw(3, rs1);
            draw(3, rs2);
            draw(3, f3);
            draw(1, alt);
            draw(20, imm);
            f7 = ((f3 == 0 || f3 == 5) && alt[0]) ? 7'b0100000 : 7'b0000000;
            imm12 = imm[11:0];
            if (f3 == 1 || f3 == 5) begin
                imm12 = {f7, imm[4:0]};
            end
            case (rs2[1:0])
                2'd0:    other_op = 7'b0000011;
                2'd1:    other_op = 7'b0100011;
                2'd2:    other_op = 7'b1100011;
                default: other_op = 7'b1110011;
            endcase
            if (kind == 0) begin
                program_mem[i] = {imm[19:0], rd[4:0], other_op};
            end else if (kind == 13) begin
                program_mem[i] = {imm[19:0], rd[4:0], rv_pkg::OP_LUI};
            end else if (kind == 14) begin
                program_mem[i] = {imm[19:0], rd[4:0], rv_pkg::OP_AUIPC};
            end else if (kind >= 7 && kind <= 12) begin
                program_mem[i] = {imm12, rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OP_I_TYPE};
            end else begin
                program_mem[i] = {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0],
                                  rv_pkg::OP_R_TYPE};
            end
        end
    endtask

    // reference model for one instruction in program order
    task automatic predict(input logic [31:0] pc, input logic [31:0] instr,
                           output logic we, output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        is_reg;
        a      = model_regs[instr[19:15]];
        is_reg = (instr[6:0] == rv_pkg::OP_R_TYPE);
        b      = is_reg ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        sh     = b[4:0];
        we     = 1'b1;
        value  = '0;
        if (is_reg || instr[6:0] == rv_pkg::OP_I_TYPE) begin
            case (instr[14:12])
                3'd0: value = (is_reg && instr[30]) ? a - b : a + b;
                3'd1: value = a << sh;
                3'd2: value = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
                3'd3: value = (a < b) ? 32'd1 : 32'd0;
                3'd4: value = a ^ b;
                3'd5: begin
                    value = a >> sh;
                    // arithmetic shift fills the vacated bits with the sign
                    if (instr[30] && a[31]) begin
                        value = value | ~(32'hffff_ffff >> sh);
                    end
                end
                3'd6: value = a | b;
                default: value = a & b;
            endcase
        end else if (instr[6:0] == rv_pkg::OP_LUI) begin
            value = {instr[31:12], 12'h000};
        end else if (instr[6:0] == rv_pkg::OP_AUIPC) begin
            value = pc + {instr[31:12], 12'h000};
        end else begin
            we = 1'b0;
        end
        if (instr[11:7] == 5'd0) begin
            we = 1'b0;
        end
    endtask

    function automatic string kind_name(input logic [6:0] opcode);
        case (opcode)
            rv_pkg::OP_R_TYPE: return "reg alu";
            rv_pkg::OP_I_TYPE: return "imm alu";
            rv_pkg::OP_LUI:    return "lui";
            rv_pkg::OP_AUIPC:  return "auipc";
            default:           return "other opcode";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            value_errors++;
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_retire();
        logic        exp_we;
        logic [31:0] exp_data;
        logic [31:0] instr;
        logic [31:0] pc;
        string       name;
        assert (retire_count < N_INSTR) else begin
            other_errors++;
            $display("retire strobe after the last instruction, pc %h", retire_pc);
        end
        if (retire_count >= N_INSTR) begin
            return;
        end
        pc    = retire_count * 4;
        instr = program_mem[retire_count];
        name  = $sformatf("%s #%0d", kind_name(instr[6:0]), retire_count);
        predict(pc, instr, exp_we, exp_data);
        check_value({name, " pc"}, pc, retire_pc);
        check_value({name, " rd"}, instr[11:7], retire_rd);
        check_value({name, " we"}, exp_we, retire_we);
        if (exp_we) begin
            check_value({name, " data"}, exp_data, retire_data);
            model_regs[instr[11:7]] = exp_data;
        end
        retire_count++;
    endtask

    // memory model and retire monitor on the falling edge
    always @(negedge clk) begin
        fetch_valid = 1'b0;
        if (rst_n) begin
            if (mem_busy) begin
                if (mem_wait == 1) begin
                    fetch_valid = 1'b1;
                    fetch_instr = program_mem[mem_addr[31:2]];
                    mem_busy    = 1'b0;
                end else begin
                    mem_wait--;
                end
            end
            if (fetch_req) begin
                check_value($sformatf("fetch addr #%0d", fetch_count), fetch_count * 4,
                            fetch_addr);
                fetch_count++;
                // past the program end the request stays unanswered
                if (fetch_addr < N_INSTR * 4) begin
                    draw(2, mem_delay);
                    mem_wait = mem_delay + 1;
                    mem_addr = fetch_addr;
                    mem_busy = 1'b1;
                end
            end
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_instr  = '0;
        lfsr         = SEED;
        mem_busy     = 1'b0;
        mem_addr     = '0;
        mem_delay    = '0;
        mem_wait     = 0;
        fetch_count  = 0;
        retire_count = 0;
        cycles       = 0;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        while (retire_count < N_INSTR && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        assert (retire_count == N_INSTR) else begin
            other_errors++;
            $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycles, retire_count, N_INSTR);
        end
        // a few more cycles to catch stray retires
        repeat (20) @(posedge clk);
        // protocol failures seen by the bound checker
        other_errors += dut0.chk0.fail_count;
        $display("retired %0d, fetches %0d, value errors %0d, other errors %0d",
                 retire_count, fetch_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/rv_pkg.sv
src/stage_slot.sv
src/fetch_unit.sv
src/decode_stage.sv
src/reg_file.sv
src/alu.sv
src/rv_core_top.sv
sim/rv_core_checker.sv
sim/tb_rv_core.sv

// ==== Makefile ====
TOP := tb_rv_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
